// File: vlog.f
ctrl_pkg.sv
ir_decoder.sv
branch_cond.sv
control_sequencer.sv
control_unit.sv
control_unit_sva.sv
tb_control_unit.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - ctrl_pkg.sv
  - ir_decoder.sv
  - branch_cond.sv
  - control_sequencer.sv
  - control_unit.sv
  - target: test
    files:
      - control_unit_sva.sv
      - tb_control_unit.sv

// File: tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit import ctrl_pkg::*; ();

  localparam int PH_RESET = 0;
  localparam int PH_F0    = 1; // fetch request held by bus_wait
  localparam int PH_F1    = 2;
  localparam int PH_F2    = 3;
  localparam int PH_E0    = 4;
  localparam int PH_E1    = 5; // write-back of two-cycle classes
  localparam int PH_FAULT = 6;

  typedef struct packed {
    ctrl_word_t ctrl;
    logic       fault;
  } expect_t;

  typedef struct packed {
    logic [31:0] instr;
    ccr_t        cc;
    logic [2:0]  waits;
  } stim_t;

  logic        clock;
  logic        reset_n;
  logic [31:0] ir;
  ccr_t        ccr;
  logic        bus_wait;
  ctrl_word_t  ctrl;
  logic        fault;

  int    phase;       // where the sequencer should be this cycle
  logic  checking;
  int    total_waits;
  int    limit_cycles;
  stim_t stims[$];

  control_unit i_control_unit (
    .clock    (clock),
    .reset_n  (reset_n),
    .ir       (ir),
    .ccr      (ccr),
    .bus_wait (bus_wait),
    .ctrl     (ctrl),
    .fault    (fault)
  );

  bind control_unit control_unit_sva i_control_unit_sva (
    .clock   (clock),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .fault   (fault)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic op_class_e classify(input logic [31:0] instr);
    logic [2:0] mode;
    logic [7:0] op;
    mode = instr[31:29];
    op   = instr[28:21];
    classify = CLS_ILLEGAL;
    if (mode == MODE_REG) begin
      case (op)
        OP_NOP:  classify = CLS_NOP;
        OP_CMP:  classify = CLS_CMP;
        OP_INC:  classify = CLS_INC;
        OP_DEC:  classify = CLS_DEC;
        OP_MOV:  classify = CLS_MOV;
        OP_COM:  classify = CLS_COM;
        OP_NEG:  classify = CLS_NEG;
        default: classify = (op[7:4] == 4'h2) ? CLS_ALU3 : CLS_ILLEGAL;
      endcase
    end else if (mode == MODE_IMM) begin
      if (op <= 8'h0b) begin
        classify = CLS_BRANCH; // bra .. brn
      end else if (op == OP_LDIS) begin
        classify = CLS_LDIS;
      end else if (op == OP_LDIU) begin
        classify = CLS_LDIU;
      end
    end else if (mode == MODE_REGIND) begin
      if (op == OP_LDA) begin
        classify = CLS_LDA;
      end else if (op == OP_JMP) begin
        classify = CLS_JMP;
      end
    end
  endfunction

  function automatic logic branch_taken(input logic [3:0] code, input ccr_t cc);
    logic lt;
    lt = cc.negative ^ cc.overflow;
    case (code)
      4'h0:    return 1'b1;
      4'h1:    return cc.zero;
      4'h2:    return !cc.zero;
      4'h3:    return !(cc.zero || cc.carry);
      4'h4:    return !(cc.zero || lt);
      4'h5:    return !lt;
      4'h6:    return cc.zero || lt;
      4'h7:    return lt;
      4'h8:    return !cc.carry;
      4'h9:    return cc.carry;
      4'ha:    return cc.carry || cc.zero;
      default: return 1'b0; // brn
    endcase
  endfunction

  function automatic expect_t expected_ctrl(input logic [31:0] instr, input int ph,
                                            input ccr_t cc);
    expect_t   e;
    op_class_e cls;
    logic      wb;
    cls = classify(instr);
    wb  = (ph == PH_E1);
    e   = '0;
    e.ctrl.alu_func       = ALU_ADD;
    e.ctrl.alu2sel        = ALU2_REG;
    e.ctrl.regsel         = REGSEL_ALU;
    e.ctrl.reg_read_addr1 = instr[20:16]; // ra
    e.ctrl.reg_read_addr2 = instr[15:11]; // rb
    e.ctrl.reg_write_addr = instr[20:16];
    e.ctrl.pcsel          = PC_HOLD;
    case (ph)
      PH_F0: e.ctrl.bus_read = 1'b1;
      PH_F1: begin
        e.ctrl.bus_read = 1'b1;
        e.ctrl.ir_write = 1'b1;
      end
      PH_F2: e.ctrl.pcsel = PC_INC;
      PH_E0, PH_E1: begin
        case (cls)
          CLS_CMP: begin
            e.ctrl.alu_func  = ALU_SUB;
            e.ctrl.ccr_write = 1'b1;
          end
          CLS_INC, CLS_DEC: begin
            e.ctrl.alu2sel   = ALU2_ONE;
            e.ctrl.alu_func  = (cls == CLS_DEC) ? ALU_SUB : ALU_ADD;
            e.ctrl.reg_write = wb;
          end
          CLS_MOV, CLS_COM, CLS_NEG, CLS_LDIS, CLS_LDIU: begin
            e.ctrl.reg_write = 1'b1;
            case (cls)
              CLS_MOV:  e.ctrl.regsel = REGSEL_MOV;
              CLS_COM:  e.ctrl.regsel = REGSEL_COM;
              CLS_NEG:  e.ctrl.regsel = REGSEL_NEG;
              CLS_LDIS: e.ctrl.regsel = REGSEL_IMMS;
              default:  e.ctrl.regsel = REGSEL_IMMU;
            endcase
          end
          CLS_ALU3: begin
            e.ctrl.alu_func       = instr[23:21];
            e.ctrl.reg_read_addr1 = instr[15:11];
            e.ctrl.reg_read_addr2 = instr[10:6]; // rc
            e.ctrl.reg_write      = wb;
          end
          CLS_BRANCH: e.ctrl.pcsel = branch_taken(instr[24:21], cc) ? PC_REL : PC_HOLD;
          CLS_LDA, CLS_JMP: begin
            e.ctrl.reg_read_addr1 = instr[15:11];
            e.ctrl.alu2sel        = ALU2_IND;
            e.ctrl.reg_write      = wb && (cls == CLS_LDA);
            e.ctrl.pcsel          = (wb && cls == CLS_JMP) ? PC_ALU : PC_HOLD;
          end
          default: e.fault = 1'b0; // nop and illegal stay quiet
        endcase
      end
      PH_FAULT: e.fault = 1'b1;
      default:  e.fault = 1'b0;   // reset
    endcase
    return e;
  endfunction

  task automatic check_value(input logic [$bits(ctrl_word_t)-1:0] actual,
                             input logic [$bits(ctrl_word_t)-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s wrong in phase %0d, expected %h, got %h",
               $time, what, phase, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  always @(posedge clock) begin
    expect_t exp_now;
    if (checking) begin
      exp_now = expected_ctrl(ir, phase, ccr);
      check_value(ctrl, exp_now.ctrl, "control word");
      check_value(fault, exp_now.fault, "fault");
    end
  end

  function automatic logic [31:0] make_instr(input logic [2:0] mode, input logic [7:0] op);
    return {mode, op, 21'($urandom)}; // random registers and low bits
  endfunction

  function automatic void add_stim(input logic [31:0] instr, input int waits);
    stim_t s;
    s.instr = instr;
    s.cc    = ccr_t'($urandom);
    s.waits = 3'(waits);
    stims.push_back(s);
    total_waits += waits;
  endfunction

  function automatic int rand_waits();
    return $urandom_range(0, 4);
  endfunction

  task automatic build_tests();
    add_stim(make_instr(MODE_REG, OP_NOP), 6); // long fetch right after reset
    add_stim(make_instr(MODE_REG, OP_CMP), rand_waits());
    add_stim(make_instr(MODE_REG, OP_MOV), rand_waits());
    add_stim(make_instr(MODE_REG, OP_COM), rand_waits());
    add_stim(make_instr(MODE_REG, OP_NEG), rand_waits());
    add_stim(make_instr(MODE_IMM, OP_LDIS), rand_waits());
    add_stim(make_instr(MODE_IMM, OP_LDIU), rand_waits());
    add_stim(make_instr(MODE_REG, OP_INC), rand_waits());
    add_stim(make_instr(MODE_REG, OP_DEC), rand_waits());
    for (int f = 0; f < 8; f++) begin
      add_stim(make_instr(MODE_REG, {OP_ALU3_GRP, 4'(f)}), rand_waits());
    end
    add_stim(make_instr(MODE_REGIND, OP_LDA), rand_waits());
    add_stim(make_instr(MODE_REGIND, OP_JMP), rand_waits());
    for (int rep = 0; rep < 4; rep++) begin
      for (int code = 0; code < 12; code++) begin
        add_stim(make_instr(MODE_IMM, {OP_BR_GRP, 4'(code)}), rand_waits());
      end
    end
    add_stim(make_instr(3'h3, 8'h10), rand_waits()); // direct mode
    add_stim(make_instr(MODE_REG, 8'h05), rand_waits());
    add_stim(make_instr(MODE_REG, 8'h30), rand_waits());
    add_stim(make_instr(MODE_IMM, 8'h0e), rand_waits());
    add_stim(make_instr(MODE_REGIND, 8'h00), rand_waits());
    add_stim(make_instr(3'h7, 8'h00), rand_waits());
    add_stim(make_instr(MODE_REG, OP_NOP), rand_waits());
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset_n  = 1'b0;
    bus_wait = 1'b0;
    phase    = PH_RESET;
    repeat (4) @(negedge clock);
    reset_n = 1'b1; // one more cycle in reset state follows
  endtask

  task automatic run_instr(input stim_t s);
    op_class_e cls;
    cls = classify(s.instr);
    for (int k = 0; k <= s.waits; k++) begin
      @(negedge clock);
      phase    = PH_F0;
      bus_wait = (k < s.waits);
    end
    @(negedge clock);
    phase    = PH_F1;
    bus_wait = 1'b0;
    @(negedge clock);
    phase = PH_F2;
    ir    = s.instr; // word latched by the ir_write cycle
    ccr   = s.cc;
    @(negedge clock);
    phase = PH_E0;
    if (cls inside {CLS_INC, CLS_DEC, CLS_ALU3, CLS_LDA, CLS_JMP}) begin
      @(negedge clock);
      phase = PH_E1;
    end else if (cls == CLS_ILLEGAL) begin
      repeat (4) begin
        @(negedge clock);
        phase    = PH_FAULT;
        ir       = $urandom; // must not wake anything up
        ccr      = ccr_t'($urandom);
        bus_wait = 1'($urandom);
      end
      apply_reset();
    end
  endtask

  initial begin
    reset_n      = 1'b0;
    ir           = '0;
    ccr          = '0;
    bus_wait     = 1'b0;
    phase        = PH_RESET;
    checking     = 1'b0;
    total_waits  = 0;
    void'($urandom(32'hdeeb_b67b));
    build_tests();
    limit_cycles = stims.size() * 20 + total_waits;
    @(negedge clock);
    checking = 1'b1;
    repeat (3) @(negedge clock);
    reset_n = 1'b1;
    foreach (stims[i]) begin
      run_instr(stims[i]);
    end
    @(negedge clock);
    phase    = PH_F0;
    bus_wait = 1'b1;
    @(negedge clock);
    checking = 1'b0;
    if (i_control_unit.i_control_unit_sva.assert_failures == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "assertion failures seen during the run");
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: control_unit_sva.sv
`timescale 1ns/1ps

module control_unit_sva import ctrl_pkg::*; (
  input logic       clock,
  input logic       reset_n,
  input ctrl_word_t ctrl,
  input logic       fault
);

  int   assert_failures = 0;
  logic any_active; // some strobe or pc update is on

  assign any_active = ctrl.bus_read | ctrl.ir_write | ctrl.reg_write | ctrl.ccr_write
                      | (ctrl.pcsel != PC_HOLD);

  // instruction word only latched while the bus read is on
  ir_write_with_bus: assert property (
    @(posedge clock) disable iff (!reset_n) ctrl.ir_write |-> ctrl.bus_read
  ) else begin
    assert_failures++;
    $error("ir_write without bus_read");
  end

  fault_sticky: assert property (
    @(posedge clock) disable iff (!reset_n) fault |=> fault
  ) else begin
    assert_failures++;
    $error("fault dropped without reset");
  end

  fault_silent: assert property (
    @(posedge clock) disable iff (!reset_n) fault |-> !any_active
  ) else begin
    assert_failures++;
    $error("control active in fault state");
  end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit import ctrl_pkg::*; (
  input  logic        clock,
  input  logic        reset_n,
  input  logic [31:0] ir,
  input  ccr_t        ccr,
  input  logic        bus_wait,
  output ctrl_word_t  ctrl,
  output logic        fault
);

  decoded_t dec;   // fields and class of the current ir
  logic     taken; // branch condition met

  ir_decoder i_ir_decoder (
    .ir  (ir),
    .dec (dec)
  );

  branch_cond i_branch_cond (
    .branch_code (dec.branch_code),
    .ccr         (ccr),
    .taken       (taken)
  );

  control_sequencer i_control_sequencer (
    .clock    (clock),
    .reset_n  (reset_n),
    .dec      (dec),
    .taken    (taken),
    .bus_wait (bus_wait),
    .ctrl     (ctrl),
    .fault    (fault)
  );

endmodule

// File: control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer import ctrl_pkg::*; (
  input  logic       clock,
  input  logic       reset_n,
  input  decoded_t   dec,
  input  logic       taken,
  input  logic       bus_wait,
  output ctrl_word_t ctrl,
  output logic       fault
);

  typedef enum logic [1:0] {
    RESET,
    FETCH,
    EVAL,
    FAULT
  } state_e;

  state_e     state;
  state_e     state_next;
  logic [1:0] step;      // sub-cycle within fetch or eval
  logic [1:0] step_next;
  logic       two_step;  // class needs a write-back cycle

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= RESET;
      step  <= 2'd0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  always_comb begin
    case (dec.op_class)
      CLS_INC, CLS_DEC, CLS_ALU3, CLS_LDA, CLS_JMP: two_step = 1'b1;
      default: two_step = 1'b0;
    endcase
  end

  // next state and step
  always_comb begin
    state_next = state;
    step_next  = step;
    case (state)
      RESET: state_next = FETCH;
      FETCH: begin
        case (step)
          2'd0: begin
            if (!bus_wait) begin
              step_next = 2'd1; // bus granted
            end
          end
          2'd1: step_next = 2'd2;
          2'd2: begin
            step_next  = 2'd0;
            state_next = EVAL;
          end
          default: state_next = FAULT;
        endcase
      end
      EVAL: begin
        if (dec.op_class == CLS_ILLEGAL) begin
          state_next = FAULT;
        end else if (two_step && step == 2'd0) begin
          step_next = 2'd1; // setup done, write back next
        end else if (step > 2'd1) begin
          state_next = FAULT;
        end else begin
          step_next  = 2'd0;
          state_next = FETCH;
        end
      end
      FAULT: state_next = FAULT; // only reset leaves
      default: state_next = FAULT;
    endcase
  end

  // control word
  always_comb begin
    ctrl                = '0;
    ctrl.alu_func       = ALU_ADD;
    ctrl.alu2sel        = ALU2_REG;
    ctrl.regsel         = REGSEL_ALU;
    ctrl.reg_read_addr1 = dec.ra;
    ctrl.reg_read_addr2 = dec.rb;
    ctrl.reg_write_addr = dec.ra;
    ctrl.pcsel          = PC_HOLD;

    case (state)
      FETCH: begin
        case (step)
          2'd0: ctrl.bus_read = 1'b1; // request instruction word
          2'd1: begin
            ctrl.bus_read = 1'b1;     // keep bus while latching
            ctrl.ir_write = 1'b1;
          end
          2'd2: ctrl.pcsel = PC_INC;
          default: ctrl.pcsel = PC_HOLD;
        endcase
      end
      EVAL: begin
        case (dec.op_class)
          CLS_CMP: begin
            ctrl.alu_func  = ALU_SUB;
            ctrl.ccr_write = 1'b1;
          end
          CLS_INC, CLS_DEC: begin
            ctrl.alu2sel   = ALU2_ONE; // ra +/- 1
            ctrl.alu_func  = (dec.op_class == CLS_DEC) ? ALU_SUB : ALU_ADD;
            ctrl.reg_write = (step == 2'd1);
          end
          CLS_MOV: begin
            ctrl.regsel    = REGSEL_MOV;
            ctrl.reg_write = 1'b1;
          end
          CLS_COM: begin
            ctrl.regsel    = REGSEL_COM;
            ctrl.reg_write = 1'b1;
          end
          CLS_NEG: begin
            ctrl.regsel    = REGSEL_NEG;
            ctrl.reg_write = 1'b1;
          end
          CLS_ALU3: begin
            ctrl.alu_func       = dec.alu_func;
            ctrl.reg_read_addr1 = dec.rb;
            ctrl.reg_read_addr2 = dec.rc;
            ctrl.reg_write      = (step == 2'd1);
          end
          CLS_BRANCH: begin
            if (taken) begin
              ctrl.pcsel = PC_REL;
            end
          end
          CLS_LDIS: begin
            ctrl.regsel    = REGSEL_IMMS;
            ctrl.reg_write = 1'b1;
          end
          CLS_LDIU: begin
            ctrl.regsel    = REGSEL_IMMU;
            ctrl.reg_write = 1'b1;
          end
          CLS_LDA: begin
            ctrl.reg_read_addr1 = dec.rb; // address is rb + offset
            ctrl.alu2sel        = ALU2_IND;
            ctrl.reg_write      = (step == 2'd1);
          end
          CLS_JMP: begin
            ctrl.reg_read_addr1 = dec.rb;
            ctrl.alu2sel        = ALU2_IND;
            if (step == 2'd1) begin
              ctrl.pcsel = PC_ALU; // pc <= rb + offset
            end
          end
          default: ctrl.pcsel = PC_HOLD; // nop and illegal do nothing
        endcase
      end
      default: ctrl.pcsel = PC_HOLD; // reset and fault stay quiet
    endcase
  end

  assign fault = (state == FAULT);

endmodule

// File: branch_cond.sv
`timescale 1ns/1ps

module branch_cond import ctrl_pkg::*; (
  input  logic [3:0] branch_code,
  input  ccr_t       ccr,
  output logic       taken
);

  logic signed_lt; // n xor v, signed less-than after cmp

  assign signed_lt = ccr.negative ^ ccr.overflow;

  always_comb begin
    case (branch_code)
      BR_BRA:  taken = 1'b1;
      BR_BEQ:  taken = ccr.zero;
      BR_BNE:  taken = ~ccr.zero;
      BR_BGTU: taken = ~(ccr.zero | ccr.carry);
      BR_BGT:  taken = ~(ccr.zero | signed_lt);
      BR_BGE:  taken = ~signed_lt;
      BR_BLE:  taken = ccr.zero | signed_lt;
      BR_BLT:  taken = signed_lt;
      BR_BGEU: taken = ~ccr.carry;
      BR_BLTU: taken = ccr.carry;
      BR_BLEU: taken = ccr.carry | ccr.zero;
      BR_BRN:  taken = 1'b0; // branch never
      default: taken = 1'b0; // decoder flags these illegal
    endcase
  end

endmodule

// File: ir_decoder.sv
`timescale 1ns/1ps

module ir_decoder import ctrl_pkg::*; (
  input  logic [31:0] ir,
  output decoded_t    dec
);

  ir_mode_t   mode;
  logic [7:0] op;
  op_class_e  op_class;

  assign mode = ir[31:29];
  assign op   = ir[28:21];

  always_comb begin
    op_class = CLS_ILLEGAL; // anything not matched below
    case (mode)
      MODE_REG: begin
        case (op)
          OP_NOP: op_class = CLS_NOP;
          OP_CMP: op_class = CLS_CMP;
          OP_INC: op_class = CLS_INC;
          OP_DEC: op_class = CLS_DEC;
          OP_MOV: op_class = CLS_MOV;
          OP_COM: op_class = CLS_COM;
          OP_NEG: op_class = CLS_NEG;
          default: begin
            if (op[7:4] == OP_ALU3_GRP) begin
              op_class = CLS_ALU3; // rA <= rB func rC
            end
          end
        endcase
      end
      MODE_IMM: begin
        if (op[7:4] == OP_BR_GRP && op[3:0] <= BR_BRN) begin
          op_class = CLS_BRANCH;
        end else if (op == OP_LDIS) begin
          op_class = CLS_LDIS;
        end else if (op == OP_LDIU) begin
          op_class = CLS_LDIU;
        end
      end
      MODE_REGIND: begin
        case (op)
          OP_LDA: op_class = CLS_LDA;
          OP_JMP: op_class = CLS_JMP;
          default: op_class = CLS_ILLEGAL;
        endcase
      end
      default: op_class = CLS_ILLEGAL; // direct mode and unused modes
    endcase
  end

  always_comb begin
    dec.op_class    = op_class;
    dec.alu_func    = op[2:0];   // only meaningful for alu3
    dec.ra          = ir[20:16];
    dec.rb          = ir[15:11];
    dec.rc          = ir[10:6];
    dec.branch_code = op[3:0];
  end

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

  typedef logic [2:0] ir_mode_t;   // ir[31:29]
  typedef logic [4:0] reg_addr_t;  // register file index
  typedef logic [2:0] alu_func_t;
  typedef logic [2:0] alu2_sel_t;
  typedef logic [2:0] reg_sel_t;
  typedef logic [2:0] pc_sel_t;

  localparam ir_mode_t MODE_REG    = 3'h0; // register operands
  localparam ir_mode_t MODE_REGIND = 3'h1; // rb plus offset
  localparam ir_mode_t MODE_IMM    = 3'h2; // immediate in low bits

  // opcode field values, ir[28:21]
  localparam logic [7:0] OP_NOP  = 8'h00;
  localparam logic [7:0] OP_CMP  = 8'h02;
  localparam logic [7:0] OP_INC  = 8'h03;
  localparam logic [7:0] OP_DEC  = 8'h04;
  localparam logic [7:0] OP_MOV  = 8'h07;
  localparam logic [7:0] OP_COM  = 8'h08;
  localparam logic [7:0] OP_NEG  = 8'h09;
  localparam logic [7:0] OP_LDA  = 8'h0a; // register-indirect mode
  localparam logic [7:0] OP_JMP  = 8'h0b; // register-indirect mode
  localparam logic [7:0] OP_LDIS = 8'h0c; // immediate mode
  localparam logic [7:0] OP_LDIU = 8'h0d; // immediate mode
  localparam logic [3:0] OP_ALU3_GRP = 4'h2; // 8'h2x, func in low bits
  localparam logic [3:0] OP_BR_GRP   = 4'h0; // 8'h0x in immediate mode

  // branch codes, low nibble of the opcode
  localparam logic [3:0] BR_BRA  = 4'h0;
  localparam logic [3:0] BR_BEQ  = 4'h1;
  localparam logic [3:0] BR_BNE  = 4'h2;
  localparam logic [3:0] BR_BGTU = 4'h3;
  localparam logic [3:0] BR_BGT  = 4'h4;
  localparam logic [3:0] BR_BGE  = 4'h5;
  localparam logic [3:0] BR_BLE  = 4'h6;
  localparam logic [3:0] BR_BLT  = 4'h7;
  localparam logic [3:0] BR_BGEU = 4'h8;
  localparam logic [3:0] BR_BLTU = 4'h9;
  localparam logic [3:0] BR_BLEU = 4'ha;
  localparam logic [3:0] BR_BRN  = 4'hb; // highest legal code

  localparam alu_func_t ALU_ADD = 3'h2;
  localparam alu_func_t ALU_SUB = 3'h3;

  localparam alu2_sel_t ALU2_REG = 3'h0; // second register port
  localparam alu2_sel_t ALU2_IND = 3'h1; // indirect offset from ir
  localparam alu2_sel_t ALU2_ONE = 3'h2; // constant one

  localparam reg_sel_t REGSEL_ALU  = 3'h0;
  localparam reg_sel_t REGSEL_NEG  = 3'h2;
  localparam reg_sel_t REGSEL_COM  = 3'h3;
  localparam reg_sel_t REGSEL_MOV  = 3'h4;
  localparam reg_sel_t REGSEL_IMMS = 3'h5; // sign-extended 16 bit
  localparam reg_sel_t REGSEL_IMMU = 3'h6; // zero-extended 16 bit

  localparam pc_sel_t PC_HOLD = 3'h0;
  localparam pc_sel_t PC_INC  = 3'h1;
  localparam pc_sel_t PC_REL  = 3'h3; // relative branch target
  localparam pc_sel_t PC_ALU  = 3'h4; // jump to alu result

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef enum logic [3:0] {
    CLS_NOP, CLS_CMP, CLS_INC, CLS_DEC, CLS_MOV, CLS_COM, CLS_NEG,
    CLS_ALU3, CLS_BRANCH, CLS_LDIS, CLS_LDIU, CLS_LDA, CLS_JMP,
    CLS_ILLEGAL
  } op_class_e;

  typedef struct packed {
    op_class_e  op_class;
    alu_func_t  alu_func;
    reg_addr_t  ra;
    reg_addr_t  rb;
    reg_addr_t  rc;
    logic [3:0] branch_code;
  } decoded_t;

  typedef struct packed {
    logic      ir_write;
    logic      ccr_write;
    alu_func_t alu_func;
    alu2_sel_t alu2sel;
    reg_sel_t  regsel;
    reg_addr_t reg_read_addr1;
    reg_addr_t reg_read_addr2;
    reg_addr_t reg_write_addr;
    logic      reg_write;
    pc_sel_t   pcsel;
    logic      bus_read;
  } ctrl_word_t;

endpackage
